// File: common/dfa_pkg.sv
package dfa_pkg;

  // State register width, wide enough for a generated DFA
  localparam int STATE_W = 11;

  // Keyword length in characters
  localparam int PATTERN_LEN = 6;

  // Reached when the whole keyword has matched
  localparam int ACCEPT_STATE = 6;

  // Keyword characters in match order
  localparam logic [7:0] PAT_R = 8'h72;
  localparam logic [7:0] PAT_L = 8'h6c;
  localparam logic [7:0] PAT_O = 8'h6f;
  localparam logic [7:0] PAT_G = 8'h67;
  localparam logic [7:0] PAT_I = 8'h69;
  localparam logic [7:0] PAT_N = 8'h6e;

  // Encoded DFA state
  // 0 is the initial state
  // 1 to 6 give the number of keyword characters matched so far
  typedef logic [STATE_W-1:0] dfa_state_t;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

  // Stream id width, one state slot per id
  localparam int SID_W = 6;

  // Number of streams tracked
  localparam int NUM_STREAMS = 1 << SID_W;

  // Matching packet counter width
  localparam int COUNT_W = 16;

  // Trailer delay so the commit sees the last character's state and accept
  localparam int EOP_DELAY = 3;

  // Minimum idle cycles after a trailer before the next header
  localparam int TRAILER_GAP = 4;

  // One input beat
  // Header carries sid, data carries chr, trailer carries neither
  typedef struct packed {
    logic             vld;
    logic             hdr;
    logic             trl;
    logic [SID_W-1:0] sid;
    logic [7:0]       chr;
  } beat_t;

  // Commands from the tracker to the matcher
  typedef struct packed {
    logic             load_state;
    logic             new_stream_id;
    logic             enable;
    logic             eop;
    logic             char_in_vld;
    logic [7:0]       char_in;
    logic [SID_W-1:0] stream_id;
  } match_ctl_t;

  // One enable table write
  typedef struct packed {
    logic             we;
    logic [SID_W-1:0] sid;
    logic             en;
  } cfg_t;

endpackage

// File: rlogin_match/rlogin_dfa.sv
module rlogin_dfa (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          char_in,
  input  logic                char_in_vld,
  input  dfa_pkg::dfa_state_t state_in,
  input  logic                state_in_vld,
  output dfa_pkg::dfa_state_t state_out,
  output logic                accept_out
);

  // Start point of this cycle's step
  dfa_pkg::dfa_state_t base_state;
  // Result of stepping base_state on char_in
  dfa_pkg::dfa_state_t step_state;

  // Literal keyword transition
  // Mismatch on 'r' restarts at state 1, anything else at 0
  function automatic dfa_pkg::dfa_state_t next_state(
    input dfa_pkg::dfa_state_t cur,
    input logic [7:0]          c
  );
    logic [7:0]          expect_c;
    dfa_pkg::dfa_state_t nxt;
    case (int'(cur))
      0:       expect_c = dfa_pkg::PAT_R;
      1:       expect_c = dfa_pkg::PAT_L;
      2:       expect_c = dfa_pkg::PAT_O;
      3:       expect_c = dfa_pkg::PAT_G;
      4:       expect_c = dfa_pkg::PAT_I;
      5:       expect_c = dfa_pkg::PAT_N;
      default: expect_c = dfa_pkg::PAT_R;
    endcase
    // Past the keyword end there is nothing left to extend
    if ((int'(cur) < dfa_pkg::PATTERN_LEN) && (c == expect_c))
    begin
      nxt = cur + dfa_pkg::dfa_state_t'(1);
    end
    else if (c == dfa_pkg::PAT_R)
    begin
      nxt = dfa_pkg::dfa_state_t'(1);
    end
    else
    begin
      nxt = '0;
    end
    return nxt;
  endfunction

  // A state load in the same cycle as a character is stepped directly
  assign base_state = state_in_vld ? state_in : state_out;
  assign step_state = next_state(base_state, char_in);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out  <= '0;
      accept_out <= 1'b0;
    end
    else
    begin
      // Accept is a single cycle pulse
      accept_out <= 1'b0;
      if (char_in_vld)
      begin
        if (step_state == dfa_pkg::dfa_state_t'(dfa_pkg::ACCEPT_STATE))
        begin
          // Full keyword seen, later matches start over
          accept_out <= 1'b1;
          state_out  <= '0;
        end
        else
        begin
          state_out <= step_state;
        end
      end
      else if (state_in_vld)
      begin
        // Restore without a character
        state_out <= state_in;
      end
    end
  end

endmodule

// File: rlogin_match/rlogin_stream_matcher.sv
module rlogin_stream_matcher (
  input  logic                               clk,
  input  logic                               rst_n,
  input  stream_pkg::match_ctl_t             ctl,
  output logic [stream_pkg::COUNT_W-1:0]     count,
  output logic                               fired
);

  // Saved DFA state, one slot per stream
  dfa_pkg::dfa_state_t state_mem [stream_pkg::NUM_STREAMS];

  // Restored state and its strobe
  dfa_pkg::dfa_state_t state_in;
  logic                state_in_vld;

  // DFA input registers
  logic [7:0]          char_in_r;
  logic                char_in_vld_r;
  dfa_pkg::dfa_state_t state_in_r;
  logic                state_in_vld_r;

  // DFA outputs and their registered copies
  dfa_pkg::dfa_state_t state_out;
  logic                accept_out;
  dfa_pkg::dfa_state_t state_out_r;
  logic                accept_out_r;

  // Set once the current packet has matched, committed at eop
  logic                spec_match;

  assign fired = spec_match;

  // Restore at each header
  // New stream starts from the initial state
  always_ff @(posedge clk)
  begin
    if (ctl.load_state)
    begin
      if (ctl.new_stream_id)
        state_in <= '0;
      else
        state_in <= state_mem[ctl.stream_id];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= ctl.load_state;
  end

  // Save the final state of an enabled stream at eop
  // A disabled stream keeps its slot as it was
  always_ff @(posedge clk)
  begin
    if (ctl.eop && ctl.enable)
      state_mem[ctl.stream_id] <= state_out_r;
  end

  // Packet match flag and the running count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      spec_match <= 1'b0;
    end
    else
    begin
      // Fresh packet, fresh flag
      if (ctl.load_state)
        spec_match <= 1'b0;
      // Any number of accepts in one packet counts once
      if (accept_out_r)
        spec_match <= 1'b1;
      if (ctl.eop)
      begin
        if (ctl.enable)
          count <= count + stream_pkg::COUNT_W'(spec_match);
        else
          // Drop the result, state was never saved
          spec_match <= 1'b0;
      end
    end
  end

  // DFA strobes, registered for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_in_vld_r  <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      char_in_vld_r  <= ctl.char_in_vld;
      state_in_vld_r <= state_in_vld;
      accept_out_r   <= accept_out;
    end
  end

  // DFA data, registered alongside the strobes
  always_ff @(posedge clk)
  begin
    char_in_r   <= ctl.char_in;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  rlogin_dfa u_rlogin_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_in_vld  (char_in_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

endmodule

// File: hw/stream_tracker.sv
module stream_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stream_pkg::beat_t      beat,
  input  stream_pkg::cfg_t       cfg,
  output stream_pkg::match_ctl_t ctl
);

  // Decoded beat kinds
  logic hdr_beat;
  logic data_beat;
  logic trl_beat;

  // Streams that have had a header since reset
  logic [stream_pkg::NUM_STREAMS-1:0] seen_q;
  // Per-stream enable, written by the config port
  logic [stream_pkg::NUM_STREAMS-1:0] enable_q;

  // Registered controls
  logic                         load_q;
  logic                         new_q;
  logic                         en_q;
  logic                         chr_vld_q;
  logic                         trl_q;
  logic [7:0]                   chr_q;
  logic [stream_pkg::SID_W-1:0] sid_q;

  // Trailer delay line
  logic [stream_pkg::EOP_DELAY-1:0] eop_sr;

  assign hdr_beat  = beat.vld & beat.hdr;
  assign trl_beat  = beat.vld & beat.trl;
  assign data_beat = beat.vld & ~beat.hdr & ~beat.trl;

  // Seen and enable tables
  // All streams start enabled and unseen
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen_q   <= '0;
      enable_q <= '1;
    end
    else
    begin
      // Marked after the new flag was sampled below
      if (hdr_beat)
        seen_q[beat.sid] <= 1'b1;
      if (cfg.we)
        enable_q[cfg.sid] <= cfg.en;
    end
  end

  // Beat decode to one-cycle pulses
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_q    <= 1'b0;
      new_q     <= 1'b0;
      en_q      <= 1'b0;
      chr_vld_q <= 1'b0;
      trl_q     <= 1'b0;
      eop_sr    <= '0;
    end
    else
    begin
      load_q    <= hdr_beat;
      chr_vld_q <= data_beat;
      trl_q     <= trl_beat;
      // Trailer waits for the last character to clear the DFA pipe
      eop_sr    <= {eop_sr[stream_pkg::EOP_DELAY-2:0], trl_q};
      // Lookups held until the delayed eop
      if (hdr_beat)
      begin
        new_q <= ~seen_q[beat.sid];
        en_q  <= enable_q[beat.sid];
      end
    end
  end

  // Character and stream id payload
  always_ff @(posedge clk)
  begin
    chr_q <= beat.chr;
    if (hdr_beat)
      sid_q <= beat.sid;
  end

  assign ctl = '{
    load_state:    load_q,
    new_stream_id: new_q,
    enable:        en_q,
    eop:           eop_sr[stream_pkg::EOP_DELAY-1],
    char_in_vld:   chr_vld_q,
    char_in:       chr_q,
    stream_id:     sid_q
  };

endmodule

// File: hw/rlogin_scan_top.sv
module rlogin_scan_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  stream_pkg::beat_t              beat,
  input  stream_pkg::cfg_t               cfg,
  output logic [stream_pkg::COUNT_W-1:0] count,
  output logic                           fired
);

  // Tracker commands to the matcher
  stream_pkg::match_ctl_t ctl;

  // Beats in, control pulses out
  stream_tracker u_stream_tracker (
    .clk   (clk),
    .rst_n (rst_n),
    .beat  (beat),
    .cfg   (cfg),
    .ctl   (ctl)
  );

  // Per-stream state around the keyword DFA
  rlogin_stream_matcher u_rlogin_stream_matcher (
    .clk   (clk),
    .rst_n (rst_n),
    .ctl   (ctl),
    .count (count),
    .fired (fired)
  );

endmodule

// File: sim/rlogin_scan_tb.sv
module rlogin_scan_tb;

  // DUT ports
  logic                           clk;
  logic                           rst_n;
  stream_pkg::beat_t              beat;
  stream_pkg::cfg_t               cfg;
  logic [stream_pkg::COUNT_W-1:0] count;
  logic                           fired;

  // Seeded random source
  int seed;

  // Reference model with one slot per stream id
  int mdl_state [stream_pkg::NUM_STREAMS];
  bit mdl_seen  [stream_pkg::NUM_STREAMS];
  bit mdl_en    [stream_pkg::NUM_STREAMS];
  bit mdl_saved [stream_pkg::NUM_STREAMS];
  int exp_count;

  // Characters of the next packet
  logic [7:0] pkt_q [$];

  // Error bookkeeping
  int test_errs;
  int total_errs;
  int tests_run;

  rlogin_scan_top UUT (
    .clk   (clk),
    .rst_n (rst_n),
    .beat  (beat),
    .cfg   (cfg),
    .count (count),
    .fired (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Inputs change a short time after each rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // Alphabet weighted toward the keyword letters
  function automatic logic [7:0] pick_char();
    int r;
    r = rand_below(10);
    case (r)
      0, 6:    pick_char = "r";
      1, 7:    pick_char = "l";
      2:       pick_char = "o";
      3:       pick_char = "g";
      4:       pick_char = "i";
      5:       pick_char = "n";
      8:       pick_char = "x";
      default: pick_char = "a";
    endcase
  endfunction

  // Keyword step that keeps the longest prefix
  // Only 'r' restarts a partial match
  function automatic int model_step(input int cur, input logic [7:0] c, output bit hit);
    string kw;
    int    nxt;
    kw  = "rlogin";
    hit = 1'b0;
    if (cur < kw.len() && c == kw[cur])
      nxt = cur + 1;
    else if (c == kw[0])
      nxt = 1;
    else
      nxt = 0;
    if (nxt == kw.len())
    begin
      hit = 1'b1;
      nxt = 0;
    end
    return nxt;
  endfunction

  function automatic stream_pkg::beat_t make_beat(input bit hdr, input bit trl,
                                                  input int sid, input logic [7:0] chr);
    make_beat = '{vld: 1'b1, hdr: hdr, trl: trl, sid: stream_pkg::SID_W'(sid), chr: chr};
  endfunction

  task automatic report_error(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0)
      $display("test %0d %s: ok", tests_run, name);
    else
      $display("test %0d %s: %0d errors", tests_run, name, test_errs);
    test_errs = 0;
  endtask

  task automatic load_string(input string s);
    pkt_q.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
  endtask

  task automatic fill_random(input int n);
    pkt_q.delete();
    for (int i = 0; i < n; i++)
      pkt_q.push_back(pick_char());
  endtask

  // Config writes only land between packets
  task automatic write_enable(input int sid, input bit en);
    cfg = '{we: 1'b1, sid: stream_pkg::SID_W'(sid), en: en};
    next_cycle();
    cfg = '0;
    mdl_en[sid] = en;
  endtask

  // Header, pkt_q as data beats, trailer, then the idle gap with checks
  task automatic send_packet(input int sid, input bit spaced, output bit matched);
    int cur;
    bit hit;
    cur = mdl_seen[sid] ? mdl_state[sid] : 0;
    mdl_seen[sid] = 1'b1;
    matched = 1'b0;
    for (int i = 0; i < pkt_q.size(); i++)
    begin
      cur = model_step(cur, pkt_q[i], hit);
      if (hit)
        matched = 1'b1;
    end
    beat = make_beat(1'b1, 1'b0, sid, 8'h00);
    next_cycle();
    for (int i = 0; i < pkt_q.size(); i++)
    begin
      beat = make_beat(1'b0, 1'b0, sid, pkt_q[i]);
      next_cycle();
      // Occasional hole between data beats
      if (spaced && rand_below(3) == 0)
      begin
        beat = '0;
        next_cycle();
      end
    end
    beat = make_beat(1'b0, 1'b1, sid, 8'h00);
    // Up to the delayed eop, fired may only rise on a match
    for (int k = 0; k <= stream_pkg::EOP_DELAY; k++)
    begin
      next_cycle();
      beat = '0;
      if (fired && !matched)
        report_error($sformatf("fired high without a match, stream %0d", sid));
    end
    if (fired !== matched)
      report_error($sformatf("fired %b before commit, expected %b", fired, matched));
    if (mdl_en[sid])
    begin
      if (matched)
        exp_count++;
      mdl_state[sid] = cur;
      mdl_saved[sid] = 1'b1;
    end
    // Count is final five cycles after the trailer
    next_cycle();
    if (count !== stream_pkg::COUNT_W'(exp_count))
      report_error($sformatf("count %0d, expected %0d", count, exp_count));
    if (fired !== (matched && mdl_en[sid]))
      report_error($sformatf("fired %b after commit, stream %0d", fired, sid));
  endtask

  initial
  begin
    bit    m;
    int    base;
    int    sid;
    int    tail_len;
    string kw;
    seed       = 32'hb915_fc85;
    rst_n      = 1'b0;
    beat       = '0;
    cfg        = '0;
    exp_count  = 0;
    test_errs  = 0;
    total_errs = 0;
    tests_run  = 0;
    kw         = "rlogin";
    for (int i = 0; i < stream_pkg::NUM_STREAMS; i++)
    begin
      mdl_state[i] = 0;
      mdl_seen[i]  = 1'b0;
      mdl_en[i]    = 1'b1;
      mdl_saved[i] = 1'b0;
    end
    repeat (4) next_cycle();
    rst_n = 1'b1;
    next_cycle();

    if (count !== '0 || fired !== 1'b0)
      report_error($sformatf("after reset count %0d fired %b", count, fired));
    end_test("reset values");

    // Whole keyword once, twice and not at all
    load_string("xrloginy");
    send_packet(1, 1'b0, m);
    load_string("rloginrlogin");
    send_packet(1, 1'b0, m);
    load_string("rlogxn");
    send_packet(1, 1'b0, m);
    load_string("rrlogin");
    send_packet(1, 1'b1, m);
    end_test("whole keyword");

    // Keyword split over two packets of stream 2
    base = int'(count);
    load_string("xxrlo");
    send_packet(2, 1'b0, m);
    load_string("abc");
    send_packet(3, 1'b0, m);
    load_string("nrgrl");
    send_packet(4, 1'b1, m);
    load_string("gin");
    send_packet(2, 1'b0, m);
    if (count !== stream_pkg::COUNT_W'(base + 1))
      report_error($sformatf("split keyword: count %0d, expected %0d", count, base + 1));
    end_test("split keyword");

    // A seen stream leaves a keyword prefix in the DFA
    // The fresh id that follows gets only the rest of the keyword
    for (int j = 0; j < 12; j++)
    begin
      tail_len = 1 + rand_below(5);
      load_string(kw.substr(0, 5 - tail_len));
      send_packet(1, 1'b0, m);
      base = int'(count);
      load_string(kw.substr(6 - tail_len, 5));
      send_packet(16 + 3 * j, 1'b0, m);
      if (count !== stream_pkg::COUNT_W'(base) || fired !== 1'b0)
        report_error($sformatf("fresh stream %0d matched on an old prefix", 16 + 3 * j));
    end
    end_test("fresh streams");

    // Disable keeps the old state and enable resumes from it
    load_string("xrlog");
    send_packet(5, 1'b0, m);
    write_enable(5, 1'b0);
    base = int'(count);
    load_string("in");
    send_packet(5, 1'b0, m);
    load_string("rlogin");
    send_packet(5, 1'b1, m);
    if (count !== stream_pkg::COUNT_W'(base))
      report_error($sformatf("disabled stream changed count to %0d", count));
    write_enable(5, 1'b1);
    load_string("in");
    send_packet(5, 1'b0, m);
    if (count !== stream_pkg::COUNT_W'(base + 1))
      report_error($sformatf("resumed stream: count %0d, expected %0d", count, base + 1));
    end_test("disable and enable");

    // Long random mix with enable toggles
    for (int n = 0; n < 300; n++)
    begin
      if (rand_below(16) == 0)
      begin
        sid = rand_below(8);
        if (mdl_saved[sid])
          write_enable(sid, rand_below(2) == 1);
      end
      fill_random(rand_below(13));
      send_packet(rand_below(8), 1'b1, m);
    end
    if (count !== stream_pkg::COUNT_W'(exp_count))
      report_error($sformatf("random run: count %0d, expected %0d", count, exp_count));
    end_test("random packets");

    $display("tests run %0d, errors %0d", tests_run, total_errs);
    if (total_errs == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: rlogin_scan_top.f
common/dfa_pkg.sv
common/stream_pkg.sv
rlogin_match/rlogin_dfa.sv
rlogin_match/rlogin_stream_matcher.sv
hw/stream_tracker.sv
hw/rlogin_scan_top.sv
sim/rlogin_scan_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the rlogin scanner testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module rlogin_scan_tb \
  -f rlogin_scan_top.f --Mdir obj_dir -o Vrlogin_scan_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vrlogin_scan_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
exit 1
